// ==== rv_frontend.f ====
+incdir+include
design/rv_pkg.sv
design/rv_intf.sv
design/rv_fetch.sv
design/rv_regfile.sv
design/rv_decode.sv
design/rv_frontend.sv
bench/rv_frontend_assertions.sv
bench/rv_frontend_tb.sv

// ==== Makefile ====
# Verilator build and run for the RV32I front end

VERILATOR ?= verilator
TOP       ?= rv_frontend_tb
FILELIST  ?= rv_frontend.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

.PHONY: simulate clean

# The simulator exits non-zero when the testbench stops with $fatal
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/rv_frontend_tb.sv ====
// Front end testbench with clock, reset, memory model, random program, reference decode, checker
`timescale 1ns/100ps
`include "rv_frontend_params.svh"

module rv_frontend_tb;

    localparam int          CLK_PERIOD     = 100;
    localparam int          RESET_CYCLES   = 16;
    localparam int          PRELOAD_CYCLES = 34;
    localparam int          NUM_INSTS      = 400;
    localparam int          MEM_WORDS      = 256;
    localparam logic [31:0] LFSR_SEED      = 32'd77;
    // A redirect under heavy back-pressure is the slowest instruction
    localparam int          TIMEOUT_CYCLES = NUM_INSTS * 12 + RESET_CYCLES + PRELOAD_CYCLES;

    logic              clk;
    logic              reset_i;
    logic              imem_req_o;
    rv_pkg::word_t     imem_addr_o;
    rv_pkg::word_t     imem_rdata_i;
    logic              wb_valid_i;
    rv_pkg::reg_addr_t wb_addr_i;
    rv_pkg::word_t     wb_data_i;
    logic              ex_valid_o;
    logic              ex_ready_i;
    rv_pkg::word_t     ex_pc_o;
    rv_pkg::word_t     ex_inst_o;
    rv_pkg::reg_addr_t ex_rd_o;
    rv_pkg::word_t     ex_op1_o;
    rv_pkg::word_t     ex_op2_o;
    rv_pkg::word_t     ex_rs2_data_o;
    rv_pkg::pc_sel_t   ex_pc_sel_o;

    rv_pkg::word_t     imem [MEM_WORDS];
    rv_pkg::word_t     ref_regs [32];
    logic [31:0]       lfsr;
    rv_pkg::word_t     exp_pc = `RV_RESET_PC;
    int                inst_count = 0;
    int                cycle_count = 0;

    rv_frontend u_dut (.*);

    // Galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    function automatic logic [31:0] draw_bits(input int nbits);
        logic [31:0] value;
        int          b;
        value = '0;
        for (b = 0; b < nbits; b++) begin
            lfsr  = lfsr_step(lfsr);
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    function automatic logic [31:0] encode_jal(input logic [31:0] offset, input logic [4:0] rd);
        return {offset[20], offset[10:1], offset[11], offset[19:12], rd, `RV_OPC_JAL};
    endfunction

    task automatic load_program();
        int          idx;
        logic [31:0] pc;
        logic [31:0] target;
        logic [31:0] offset;
        logic [31:0] fields;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        for (idx = 0; idx < MEM_WORDS; idx++) begin
            pc     = 32'(idx) << 2;
            // Every jump or branch lands on a word inside the memory
            target = draw_bits(8) << 2;
            offset = target - pc;
            fields = draw_bits(25);
            f3     = 3'(draw_bits(3));
            // 010 and 011 are not branches, fold them onto BLTU and BGEU
            if (f3[2:1] == 2'b01) f3[2] = 1'b1;
            // Same register half the time so equal compares show up
            rs2    = fields[20] ? fields[14:10] : fields[9:5];
            case (draw_bits(4) % 32'd9)
                0: imem[idx] = {fields[24:0], `RV_OPC_LUI};
                1: imem[idx] = {fields[24:0], `RV_OPC_AUIPC};
                2: imem[idx] = {fields[24:0], `RV_OPC_LOAD};
                3: imem[idx] = {fields[24:0], `RV_OPC_STORE};
                4: imem[idx] = {fields[24:0], `RV_OPC_OP_IMM};
                5: imem[idx] = {fields[24:0], `RV_OPC_OP};
                6: imem[idx] = encode_jal(offset, fields[4:0]);
                // JALR from x0, so the target is the absolute I immediate
                7: imem[idx] = {target[11:0], 5'd0, 3'b000, fields[4:0], `RV_OPC_JALR};
                default: imem[idx] = {offset[12], offset[10:5], rs2, fields[14:10], f3,
                                      offset[4:1], offset[11], `RV_OPC_BRANCH};
            endcase
        end
        // Last word jumps back to the start instead of running off the end
        imem[MEM_WORDS - 1] = encode_jal(32'd0 - (32'(MEM_WORDS - 1) << 2), 5'd1);
    endtask

    task automatic preload_registers();
        int          idx;
        logic [31:0] value;
        for (idx = 0; idx < 32; idx++) begin
            @(posedge clk);
            value = draw_bits(32);
            wb_valid_i <= 1'b1;
            wb_addr_i  <= 5'(idx);
            wb_data_i  <= value;
            // x0 gets the write attempt but keeps reading zero
            if (idx != 0) ref_regs[idx] = value;
        end
        @(posedge clk);
        wb_valid_i <= 1'b0;
    endtask

    // Expected execute outputs and next PC of one instruction at one PC
    function automatic void ref_decode(
        input  logic [31:0] inst,
        input  logic [31:0] pc,
        input  logic [31:0] regs [32],
        output logic [31:0] op1,
        output logic [31:0] op2,
        output logic [31:0] rs2_data,
        output logic [4:0]  rd,
        output logic [1:0]  pc_sel,
        output logic [31:0] next_pc
    );
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic        taken;
        a        = regs[inst[19:15]];
        b        = regs[inst[24:20]];
        imm_i    = 32'($signed(inst[31:20]));
        imm_s    = 32'($signed({inst[31:25], inst[11:7]}));
        imm_b    = 32'($signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}));
        imm_u    = {inst[31:12], 12'h000};
        imm_j    = 32'($signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}));
        rd       = inst[11:7];
        rs2_data = b;
        op1      = a;
        op2      = imm_i;
        pc_sel   = `RV_PC_SEQ;
        next_pc  = pc + 32'd4;
        case (inst[14:12])
            `RV_F3_BEQ:  taken = (a == b);
            `RV_F3_BNE:  taken = (a != b);
            `RV_F3_BLT:  taken = ($signed(a) < $signed(b));
            `RV_F3_BGE:  taken = ($signed(a) >= $signed(b));
            `RV_F3_BLTU: taken = (a < b);
            `RV_F3_BGEU: taken = (a >= b);
            default:     taken = 1'b0;
        endcase
        case (inst[6:0])
            `RV_OPC_LUI: begin
                op1 = imm_u;
            end
            `RV_OPC_AUIPC: begin
                op1 = imm_u;
                op2 = pc;
            end
            `RV_OPC_STORE: op2 = imm_s;
            `RV_OPC_OP:    op2 = b;
            `RV_OPC_JAL: begin
                pc_sel  = `RV_PC_JAL;
                next_pc = pc + imm_j;
            end
            `RV_OPC_JALR: begin
                pc_sel  = `RV_PC_JALR;
                next_pc = (a + imm_i) & 32'hFFFF_FFFE;
            end
            `RV_OPC_BRANCH: begin
                if (taken) begin
                    pc_sel  = `RV_PC_BR;
                    next_pc = pc + imm_b;
                end
            end
            default: ;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            $display("Verification failed");
            $fatal(1, "Mismatch on %s at PC 0x%08h", name, exp_pc);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Instruction memory with one-cycle registered read
    initial begin
        imem_rdata_i <= '0;
        forever begin
            @(posedge clk);
            if (imem_req_o) imem_rdata_i <= imem[imem_addr_o[9:2]];
        end
    end

    initial begin
        reset_i    <= 1'b1;
        wb_valid_i <= 1'b0;
        wb_addr_i  <= '0;
        wb_data_i  <= '0;
        ex_ready_i <= 1'b0;
        lfsr = LFSR_SEED;
        foreach (ref_regs[i]) ref_regs[i] = '0;
        load_program();
        repeat (RESET_CYCLES) @(posedge clk);
        reset_i <= 1'b0;
        preload_registers();
        // Execute stage ready three cycles in four
        forever begin
            @(posedge clk);
            ex_ready_i <= (draw_bits(2) != 32'd0);
        end
    end

    always @(posedge clk) begin
        rv_pkg::word_t exp_inst;
        rv_pkg::word_t exp_op1;
        rv_pkg::word_t exp_op2;
        rv_pkg::word_t exp_rs2;
        logic [4:0]    exp_rd;
        logic [1:0]    exp_sel;
        rv_pkg::word_t exp_next;
        if (!reset_i && ex_valid_o && ex_ready_i) begin
            exp_inst = imem[exp_pc[9:2]];
            ref_decode(exp_inst, exp_pc, ref_regs, exp_op1, exp_op2, exp_rs2, exp_rd,
                       exp_sel, exp_next);
            check_value("ex_pc_o", ex_pc_o, exp_pc);
            check_value("ex_inst_o", ex_inst_o, exp_inst);
            check_value("ex_rd_o", 32'(ex_rd_o), 32'(exp_rd));
            check_value("ex_op1_o", ex_op1_o, exp_op1);
            check_value("ex_op2_o", ex_op2_o, exp_op2);
            check_value("ex_rs2_data_o", ex_rs2_data_o, exp_rs2);
            check_value("ex_pc_sel_o", 32'(ex_pc_sel_o), 32'(exp_sel));
            // Program order, nothing skipped and nothing past a taken transfer
            exp_pc     = exp_next;
            inst_count = inst_count + 1;
            if (inst_count == NUM_INSTS) begin
                $display("Verification passed");
                $finish;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Verification failed");
            $fatal(1, "Timeout after %0d cycles with only %0d of %0d instructions checked",
                   cycle_count, inst_count, NUM_INSTS);
        end
    end

endmodule

// ==== bench/rv_frontend_assertions.sv ====
// Protocol checker for the front end top level and its bind statement
`timescale 1ns/100ps

module rv_frontend_assertions (
    input logic              clk,
    input logic              reset_i,
    input logic              imem_req_i,
    input logic              wb_valid_i,
    input logic              ex_valid_i,
    input logic              ex_ready_i,
    input rv_pkg::word_t     ex_pc_i,
    input rv_pkg::word_t     ex_inst_i,
    input rv_pkg::reg_addr_t ex_rd_i,
    input rv_pkg::word_t     ex_op1_i,
    input rv_pkg::word_t     ex_op2_i,
    input rv_pkg::word_t     ex_rs2_data_i,
    input rv_pkg::pc_sel_t   ex_pc_sel_i,
    input logic              redirect_valid_i
);

    // Stalled execute transfer keeps its contents unless a write-back lands
    a_ex_hold : assert property (@(posedge clk) disable iff (reset_i)
        (ex_valid_i && !ex_ready_i && !wb_valid_i) |=>
            (ex_valid_i && $stable(ex_pc_i) && $stable(ex_inst_i) && $stable(ex_rd_i) &&
             $stable(ex_op1_i) && $stable(ex_op2_i) && $stable(ex_rs2_data_i) &&
             $stable(ex_pc_sel_i)))
        else $error("execute outputs changed while execute was stalled");

    // Once reset has taken effect
    a_reset_quiet : assert property (@(posedge clk)
        (reset_i && $past(reset_i)) |-> !imem_req_i)
        else $error("instruction memory request issued during reset");

    // Decode empties behind a taken transfer while the target is fetched
    a_redirect_flush : assert property (@(posedge clk) disable iff (reset_i)
        redirect_valid_i |=> !ex_valid_i)
        else $error("instruction behind a redirect reached the execute port");

endmodule

bind rv_frontend rv_frontend_assertions u_assertions (
    .clk              (clk),
    .reset_i          (reset_i),
    .imem_req_i       (imem_req_o),
    .wb_valid_i       (wb_valid_i),
    .ex_valid_i       (ex_valid_o),
    .ex_ready_i       (ex_ready_i),
    .ex_pc_i          (ex_pc_o),
    .ex_inst_i        (ex_inst_o),
    .ex_rd_i          (ex_rd_o),
    .ex_op1_i         (ex_op1_o),
    .ex_op2_i         (ex_op2_o),
    .ex_rs2_data_i    (ex_rs2_data_o),
    .ex_pc_sel_i      (ex_pc_sel_o),
    .redirect_valid_i (redirect_valid)
);

// ==== design/rv_frontend.sv ====
// Front end top level: fetch, register file and decode wired to plain ports
`timescale 1ns/100ps

module rv_frontend (
    input  logic              clk,
    input  logic              reset_i,

    // Instruction memory, one-cycle read
    output logic              imem_req_o,
    output rv_pkg::word_t     imem_addr_o,
    input  rv_pkg::word_t     imem_rdata_i,

    // Register write-back
    input  logic              wb_valid_i,
    input  rv_pkg::reg_addr_t wb_addr_i,
    input  rv_pkg::word_t     wb_data_i,

    // Execute stage
    output logic              ex_valid_o,
    input  logic              ex_ready_i,
    output rv_pkg::word_t     ex_pc_o,
    output rv_pkg::word_t     ex_inst_o,
    output rv_pkg::reg_addr_t ex_rd_o,
    output rv_pkg::word_t     ex_op1_o,
    output rv_pkg::word_t     ex_op2_o,
    output rv_pkg::word_t     ex_rs2_data_o,
    output rv_pkg::pc_sel_t   ex_pc_sel_o
);

    logic          redirect_valid;
    rv_pkg::word_t redirect_target;

    fetch_if   fetch_bus ();
    regread_if regread_bus ();

    rv_fetch u_fetch (
        .clk               (clk),
        .reset_i           (reset_i),
        .fetch_o           (fetch_bus),
        .redirect_valid_i  (redirect_valid),
        .redirect_target_i (redirect_target),
        .imem_req_o        (imem_req_o),
        .imem_addr_o       (imem_addr_o),
        .imem_rdata_i      (imem_rdata_i)
    );

    rv_regfile u_regfile (
        .clk        (clk),
        .reset_i    (reset_i),
        .rd_o       (regread_bus),
        .wb_valid_i (wb_valid_i),
        .wb_addr_i  (wb_addr_i),
        .wb_data_i  (wb_data_i)
    );

    rv_decode u_decode (
        .clk               (clk),
        .reset_i           (reset_i),
        .fetch_i           (fetch_bus),
        .rd_i              (regread_bus),
        .ex_valid_o        (ex_valid_o),
        .ex_ready_i        (ex_ready_i),
        .ex_pc_o           (ex_pc_o),
        .ex_inst_o         (ex_inst_o),
        .ex_rd_o           (ex_rd_o),
        .ex_op1_o          (ex_op1_o),
        .ex_op2_o          (ex_op2_o),
        .ex_rs2_data_o     (ex_rs2_data_o),
        .ex_pc_sel_o       (ex_pc_sel_o),
        .redirect_valid_o  (redirect_valid),
        .redirect_target_o (redirect_target)
    );

endmodule

// ==== design/rv_decode.sv ====
// Decode unit: pipeline register, immediates, operand select, branch resolve and redirect
`timescale 1ns/100ps
`include "rv_frontend_params.svh"

module rv_decode (
    input  logic              clk,
    input  logic              reset_i,
    fetch_if.decode           fetch_i,
    regread_if.decode         rd_i,
    output logic              ex_valid_o,
    input  logic              ex_ready_i,
    output rv_pkg::word_t     ex_pc_o,
    output rv_pkg::word_t     ex_inst_o,
    output rv_pkg::reg_addr_t ex_rd_o,
    output rv_pkg::word_t     ex_op1_o,
    output rv_pkg::word_t     ex_op2_o,
    output rv_pkg::word_t     ex_rs2_data_o,
    output rv_pkg::pc_sel_t   ex_pc_sel_o,
    output logic              redirect_valid_o,
    output rv_pkg::word_t     redirect_target_o
);

    logic              valid_q;
    rv_pkg::word_t     pc_q;
    rv_pkg::word_t     inst_q;
    rv_pkg::opcode_t   opcode;
    rv_pkg::funct3_t   funct3;
    rv_pkg::word_t     imm_i;
    rv_pkg::word_t     imm_s;
    rv_pkg::word_t     imm_b;
    rv_pkg::word_t     imm_u;
    rv_pkg::word_t     imm_j;
    rv_pkg::op1_sel_t  op1_sel;
    rv_pkg::op2_sel_t  op2_sel;
    rv_pkg::pc_sel_t   pc_sel;
    rv_pkg::word_t     target;
    logic              br_eq;
    logic              br_lt;
    logic              br_ltu;
    logic              br_taken;
    logic              ex_fire;
    logic              non_seq;

    assign ex_fire = valid_q && ex_ready_i;
    assign non_seq = (pc_sel != `RV_PC_SEQ);

    // Nothing behind a control transfer gets in
    assign fetch_i.ready = !valid_q || (ex_fire && !non_seq);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (fetch_i.valid && fetch_i.ready) begin
            valid_q <= 1'b1;
        end else if (ex_fire) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_i.valid && fetch_i.ready) begin
            pc_q   <= fetch_i.pc;
            inst_q <= fetch_i.inst;
        end
    end

    // Fields of the held instruction
    assign opcode         = inst_q[6:0];
    assign funct3         = inst_q[14:12];
    assign rd_i.rs1_addr  = inst_q[19:15];
    assign rd_i.rs2_addr  = inst_q[24:20];

    // Sign-extended immediates
    assign imm_i = {{20{inst_q[31]}}, inst_q[31:20]};
    assign imm_s = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
    assign imm_b = {{19{inst_q[31]}}, inst_q[31], inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};
    assign imm_u = {inst_q[31:12], 12'b0};
    assign imm_j = {{11{inst_q[31]}}, inst_q[31], inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};

    always_comb begin
        op1_sel = `RV_OP1_RS1;
        op2_sel = `RV_OP2_IIMM;
        case (opcode)
            `RV_OPC_LUI: begin
                op1_sel = `RV_OP1_UIMM;
            end
            `RV_OPC_AUIPC: begin
                op1_sel = `RV_OP1_UIMM;
                op2_sel = `RV_OP2_PC;
            end
            `RV_OPC_STORE: op2_sel = `RV_OP2_SIMM;
            `RV_OPC_OP:    op2_sel = `RV_OP2_RS2;
            default:       op2_sel = `RV_OP2_IIMM;
        endcase
    end

    assign ex_op1_o = (op1_sel == `RV_OP1_UIMM) ? imm_u : rd_i.rs1_data;

    always_comb begin
        case (op2_sel)
            `RV_OP2_SIMM: ex_op2_o = imm_s;
            `RV_OP2_RS2:  ex_op2_o = rd_i.rs2_data;
            `RV_OP2_PC:   ex_op2_o = pc_q;
            default:      ex_op2_o = imm_i;
        endcase
    end

    // Branch compare
    assign br_eq  = (rd_i.rs1_data == rd_i.rs2_data);
    assign br_lt  = ($signed(rd_i.rs1_data) < $signed(rd_i.rs2_data));
    assign br_ltu = (rd_i.rs1_data < rd_i.rs2_data);

    always_comb begin
        case (funct3)
            `RV_F3_BEQ:  br_taken = br_eq;
            `RV_F3_BNE:  br_taken = !br_eq;
            `RV_F3_BLT:  br_taken = br_lt;
            `RV_F3_BGE:  br_taken = !br_lt;
            `RV_F3_BLTU: br_taken = br_ltu;
            `RV_F3_BGEU: br_taken = !br_ltu;
            default:     br_taken = 1'b0;
        endcase
    end

    always_comb begin
        if (opcode == `RV_OPC_JAL) begin
            pc_sel = `RV_PC_JAL;
        end else if (opcode == `RV_OPC_JALR) begin
            pc_sel = `RV_PC_JALR;
        end else if ((opcode == `RV_OPC_BRANCH) && br_taken) begin
            pc_sel = `RV_PC_BR;
        end else begin
            pc_sel = `RV_PC_SEQ;
        end
    end

    // Next PC, JALR clears bit 0
    always_comb begin
        case (pc_sel)
            `RV_PC_JALR: target = (rd_i.rs1_data + imm_i) & ~32'd1;
            `RV_PC_BR:   target = pc_q + imm_b;
            `RV_PC_JAL:  target = pc_q + imm_j;
            default:     target = pc_q + 32'd4;
        endcase
    end

    assign ex_valid_o    = valid_q;
    assign ex_pc_o       = pc_q;
    assign ex_inst_o     = inst_q;
    assign ex_rd_o       = inst_q[11:7];
    assign ex_rs2_data_o = rd_i.rs2_data;
    assign ex_pc_sel_o   = pc_sel;

    // Redirect only when execute takes the transfer
    assign redirect_valid_o  = ex_fire && non_seq;
    assign redirect_target_o = target;

endmodule

// ==== design/rv_regfile.sv ====
// Register file: 32 x 32-bit, two combinational reads, one write port, x0 fixed at zero
`timescale 1ns/100ps

module rv_regfile (
    input  logic              clk,
    input  logic              reset_i,
    regread_if.regfile        rd_o,
    input  logic              wb_valid_i,
    input  rv_pkg::reg_addr_t wb_addr_i,
    input  rv_pkg::word_t     wb_data_i
);

    rv_pkg::word_t regs [0:31];
    logic          wb_en;

    // x0 is never written, so its reset value of zero stays
    assign wb_en = wb_valid_i && (wb_addr_i != 5'd0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_addr_i] <= wb_data_i;
        end
    end

    // Reads see the array directly, no bypass from the write port
    assign rd_o.rs1_data = regs[rd_o.rs1_addr];
    assign rd_o.rs2_data = regs[rd_o.rs2_addr];

endmodule

// ==== design/rv_fetch.sv ====
// Fetch unit: PC sequencing, instruction memory requests, holding buffer, redirect flush
`timescale 1ns/100ps
`include "rv_frontend_params.svh"

module rv_fetch (
    input  logic          clk,
    input  logic          reset_i,
    fetch_if.fetch        fetch_o,
    input  logic          redirect_valid_i,
    input  rv_pkg::word_t redirect_target_i,
    output logic          imem_req_o,
    output rv_pkg::word_t imem_addr_o,
    input  rv_pkg::word_t imem_rdata_i
);

    rv_pkg::fetch_state_t state_q;
    rv_pkg::fetch_state_t state_d;
    rv_pkg::word_t        next_pc_q;
    rv_pkg::word_t        flight_pc_q;
    rv_pkg::word_t        hold_inst_q;
    logic                 run_q;
    logic                 accept;

    // A word is on offer whenever one is in flight or parked
    assign fetch_o.valid = (state_q == rv_pkg::FETCH_WAIT) || (state_q == rv_pkg::FETCH_HOLD);
    assign fetch_o.pc    = flight_pc_q;
    assign fetch_o.inst  = (state_q == rv_pkg::FETCH_HOLD) ? hold_inst_q : imem_rdata_i;
    assign accept        = fetch_o.valid && fetch_o.ready;

    // New request on redirect, on handoff, or once out of reset
    assign imem_req_o  = redirect_valid_i || accept ||
                         ((state_q == rv_pkg::FETCH_IDLE) && run_q);
    assign imem_addr_o = redirect_valid_i ? redirect_target_i : next_pc_q;

    always_comb begin
        state_d = state_q;
        if (redirect_valid_i) begin
            // Drop whatever is buffered or in flight
            state_d = rv_pkg::FETCH_WAIT;
        end else begin
            case (state_q)
                rv_pkg::FETCH_IDLE: if (run_q) state_d = rv_pkg::FETCH_WAIT;
                rv_pkg::FETCH_WAIT: if (!fetch_o.ready) state_d = rv_pkg::FETCH_HOLD;
                rv_pkg::FETCH_HOLD: if (fetch_o.ready) state_d = rv_pkg::FETCH_WAIT;
                default:            state_d = rv_pkg::FETCH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q   <= rv_pkg::FETCH_IDLE;
            run_q     <= 1'b0;
            next_pc_q <= `RV_RESET_PC;
        end else begin
            state_q <= state_d;
            run_q   <= 1'b1;
            if (imem_req_o) begin
                next_pc_q <= imem_addr_o + 32'd4;
            end
        end
    end

    // PC follows its word; decode stall parks the returning word
    always_ff @(posedge clk) begin
        if (imem_req_o) begin
            flight_pc_q <= imem_addr_o;
        end
        if ((state_q == rv_pkg::FETCH_WAIT) && !fetch_o.ready) begin
            hold_inst_q <= imem_rdata_i;
        end
    end

endmodule

// ==== design/rv_intf.sv ====
// Fetch-to-decode handshake interface and register read interface, with modports
`timescale 1ns/100ps

// Instruction handoff from fetch to decode
interface fetch_if;

    logic          valid;
    logic          ready;
    rv_pkg::word_t pc;
    rv_pkg::word_t inst;

    // pc and inst stay stable while valid waits on ready
    modport fetch (
        output valid,
        output pc,
        output inst,
        input  ready
    );

    modport decode (
        input  valid,
        input  pc,
        input  inst,
        output ready
    );

endinterface

// Two combinational register reads
interface regread_if;

    rv_pkg::reg_addr_t rs1_addr;
    rv_pkg::reg_addr_t rs2_addr;
    rv_pkg::word_t     rs1_data;
    rv_pkg::word_t     rs2_data;

    modport decode (
        output rs1_addr,
        output rs2_addr,
        input  rs1_data,
        input  rs2_data
    );

    modport regfile (
        input  rs1_addr,
        input  rs2_addr,
        output rs1_data,
        output rs2_data
    );

endinterface

// ==== design/rv_pkg.sv ====
// Front end package: word, field and selector typedefs and the fetch state enum
package rv_pkg;

    // Data word, PC or raw instruction
    typedef logic [31:0] word_t;

    // Register index
    typedef logic [4:0] reg_addr_t;

    // Instruction fields
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;

    // Next PC source, encoded by the RV_PC_* macros
    typedef logic [1:0] pc_sel_t;

    // Operand 1 source, rs1 or U immediate
    typedef logic op1_sel_t;

    // Operand 2 source, I or S immediate, rs2 or PC
    typedef logic [1:0] op2_sel_t;

    // Fetch FSM
    // IDLE issues the first request after reset
    // WAIT offers the word coming back from memory
    // HOLD offers the word parked in the buffer
    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_WAIT,
        FETCH_HOLD
    } fetch_state_t;

endpackage

// ==== include/rv_frontend_params.svh ====
// Reset PC, RV32I opcodes, branch funct3 codes and datapath selector encodings
`ifndef RV_FRONTEND_PARAMS_SVH
`define RV_FRONTEND_PARAMS_SVH

// First fetch address
`define RV_RESET_PC      32'h0000_0000

// Major opcodes
`define RV_OPC_LUI       7'b0110111
`define RV_OPC_AUIPC     7'b0010111
`define RV_OPC_JAL       7'b1101111
`define RV_OPC_JALR      7'b1100111
`define RV_OPC_BRANCH    7'b1100011
`define RV_OPC_LOAD      7'b0000011
`define RV_OPC_STORE     7'b0100011
`define RV_OPC_OP_IMM    7'b0010011
`define RV_OPC_OP        7'b0110011

// Branch conditions
`define RV_F3_BEQ        3'b000
`define RV_F3_BNE        3'b001
`define RV_F3_BLT        3'b100
`define RV_F3_BGE        3'b101
`define RV_F3_BLTU       3'b110
`define RV_F3_BGEU       3'b111

// Next PC source
`define RV_PC_SEQ        2'd0
`define RV_PC_JALR       2'd1
`define RV_PC_BR         2'd2
`define RV_PC_JAL        2'd3

// Operand selectors
`define RV_OP1_RS1       1'b0
`define RV_OP1_UIMM      1'b1
`define RV_OP2_IIMM      2'd0
`define RV_OP2_SIMM      2'd1
`define RV_OP2_RS2       2'd2
`define RV_OP2_PC        2'd3

`endif
